// File: r5p.f
verilog/riscv_isa_pkg.sv
verilog/r5p_ctl_pkg.sv
verilog/r5p_dec.sv
verilog/r5p_gpr.sv
verilog/r5p_alu.sv
verilog/r5p_br.sv
verilog/r5p_lsu.sv
verilog/r5p_core.sv
verilog/r5p_top.sv
+incdir+verif
verif/r5p_tb.sv

// File: run.sh
#!/bin/sh
# build and run the r5p testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f r5p.f --top-module r5p_tb -o r5p_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/r5p_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

// File: verif/r5p_iss.svh
`ifndef R5P_ISS_SVH
`define R5P_ISS_SVH

//////////////////////////////////////////////////
// RV32I reference model state
//////////////////////////////////////////////////

logic [31:0] iss_x [0:31];
logic [31:0] iss_pc;
// shadow of the 256-byte data region
logic [31:0] iss_mem [0:63];
// data bus access the last step expects
logic        exp_vld;
logic        exp_wen;
logic [31:0] exp_adr;
logic [3:0]  exp_sel;
logic [31:0] exp_wdt;

function automatic logic [31:0] sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// RV32I branch conditions
function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return !($signed(a) < $signed(b));
    3'd6: return a < b;
    3'd7: return !(a < b);
    default: return 1'b0;
  endcase
endfunction

// OP and OP-IMM, alt picks SUB or SRA
function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// byte lanes touched by an access
function automatic logic [3:0] lanes(input logic [1:0] size, input logic [1:0] off);
  case (size)
    2'd0: return 4'b0001 << off;
    2'd1: return off[1] ? 4'b1100 : 4'b0011;
    default: return 4'b1111;
  endcase
endfunction

// shift the addressed item down, then extend by funct3
function automatic logic [31:0] load_ext(input logic [2:0] f3, input logic [1:0] off,
                                         input logic [31:0] wrd);
  logic [31:0] sh;
  sh = wrd >> {off, 3'b000};
  case (f3)
    3'd0: return {{24{sh[7]}}, sh[7:0]};
    3'd1: return {{16{sh[15]}}, sh[15:0]};
    3'd4: return {24'd0, sh[7:0]};
    3'd5: return {16'd0, sh[15:0]};
    default: return sh;
  endcase
endfunction

// executes one instruction word at iss_pc
task automatic iss_step(input logic [31:0] w);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] immb;
  logic [31:0] immj;
  logic [31:0] res;
  logic [31:0] adr;
  logic [31:0] npc;
  logic [2:0]  f3;
  logic        wr;
  a    = iss_x[w[19:15]];
  b    = iss_x[w[24:20]];
  f3   = w[14:12];
  immb = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  immj = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  npc  = iss_pc + 32'd4;
  res  = 32'd0;
  adr  = 32'd0;
  wr   = 1'b1;
  exp_vld = 1'b0;
  case (w[6:0])
    7'h37: res = {w[31:12], 12'h000};
    7'h17: res = iss_pc + {w[31:12], 12'h000};
    7'h6f: begin
      res = iss_pc + 32'd4;
      npc = iss_pc + immj;
    end
    7'h67: begin
      res = iss_pc + 32'd4;
      npc = (a + sext12(w[31:20])) & ~32'd1;
    end
    7'h63: begin
      wr = 1'b0;
      if (branch_taken(f3, a, b)) begin
        npc = iss_pc + immb;
      end
    end
    7'h03: begin
      adr = a + sext12(w[31:20]);
      res = load_ext(f3, adr[1:0], iss_mem[adr[7:2]]);
      exp_vld = 1'b1;
      exp_wen = 1'b0;
      exp_sel = lanes(f3[1:0], adr[1:0]);
    end
    7'h23: begin
      wr = 1'b0;
      adr = a + sext12({w[31:25], w[11:7]});
      exp_vld = 1'b1;
      exp_wen = 1'b1;
      exp_sel = lanes(f3[1:0], adr[1:0]);
      exp_wdt = (f3[1:0] == 2'd2) ? b : b << {adr[1:0], 3'b000};
      for (int k = 0; k < 4; k++) begin
        if (exp_sel[k]) begin
          iss_mem[adr[7:2]][8*k +: 8] = exp_wdt[8*k +: 8];
        end
      end
    end
    // only SRAI takes the alternate encoding
    7'h13: res = int_op(f3, w[30] & (f3 == 3'd5), a, sext12(w[31:20]));
    7'h33: res = int_op(f3, w[30], a, b);
    default: wr = 1'b0;
  endcase
  exp_adr = {adr[31:2], 2'b00};
  if (wr && (w[11:7] != 5'd0)) begin
    iss_x[w[11:7]] = res;
  end
  iss_pc = npc;
endtask

`endif

// File: verif/r5p_tb.sv
`timescale 1ns/10ps

module r5p_tb;

localparam int N_INSN     = 2000;
localparam int MAX_CYCLES = 4 * N_INSN * 2;

logic        clk;
logic        rst;
logic        if_req;
logic [31:0] if_adr;
logic [31:0] if_rdt;
logic        if_ack;
logic        ls_req;
logic        ls_wen;
logic [31:0] ls_adr;
logic [3:0]  ls_sel;
logic [31:0] ls_wdt;
logic [31:0] ls_rdt;
logic        ls_ack;

// bus side memories
logic [31:0] pmem [0:255];
logic [31:0] dmem [0:63];
logic [31:0] lcg_state;
// per test counters for reset, fetch, store and load
int          test_chk [0:3];
int          test_err [0:3];
logic        fetch_pend;
logic [31:0] fetch_adr;
logic        done_run;
logic        timed_out;
int          steps;
int          cycles;

`include "r5p_iss.svh"

r5p_top r5p_top_inst (
  .clk    (clk),
  .rst    (rst),
  .if_req (if_req),
  .if_adr (if_adr),
  .if_rdt (if_rdt),
  .if_ack (if_ack),
  .ls_req (ls_req),
  .ls_wen (ls_wen),
  .ls_adr (ls_adr),
  .ls_sel (ls_sel),
  .ls_wdt (ls_wdt),
  .ls_rdt (ls_rdt),
  .ls_ack (ls_ack)
);

initial begin
  clk = 1'b0;
  forever #4 clk = ~clk;
end

//////////////////////////////////////////////////
// random source and program
//////////////////////////////////////////////////

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state ^ (lcg_state >> 16);
endfunction

function automatic logic [31:0] random_insn(input int idx);
  logic [31:0] r;
  logic [31:0] s;
  logic [20:0] jo;
  logic [12:0] bo;
  logic [11:0] im;
  logic [7:0]  a8;
  logic [2:0]  f3;
  r  = lcg_next();
  s  = lcg_next();
  f3 = s[20:18];
  // every fourth slot is a word store of a random register
  if (idx % 4 == 3) begin
    im = {4'd0, s[31:26], 2'b00};
    return {im[11:5], r[24:20], 5'd0, 3'b010, im[4:0], 7'h23};
  end
  case (s[3:0])
    4'd0: return {r[31:12], r[11:7], 7'h37};
    4'd1: return {r[31:12], r[11:7], 7'h17};
    4'd2: begin
      // short offsets that never jump to themselves
      jo = {{13{s[10]}}, s[10:5], 2'b00};
      if (jo == 21'd0) jo = 21'd4;
      return {jo[20], jo[10:1], jo[11], jo[19:12], r[11:7], 7'h6f};
    end
    4'd3: begin
      im = {s[13:4], 2'b00};
      if (im[9:2] == 8'(idx)) im[2] = ~im[2];
      return {im, 5'd0, 3'b000, r[11:7], 7'h67};
    end
    4'd4: begin
      bo = {{5{s[10]}}, s[10:5], 2'b00};
      if (bo == 13'd0) bo = 13'd4;
      // 010 and 011 are not branches
      if (f3[2:1] == 2'b01) f3[1] = 1'b0;
      return {bo[12], bo[10:5], r[24:20], r[19:15], f3, bo[4:1], bo[11], 7'h63};
    end
    4'd5, 4'd6: begin
      if (f3 == 3'd3) f3 = 3'd2;
      if (f3[2:1] == 2'b11) f3[1] = 1'b0;
      a8 = s[31:24];
      if (f3[1:0] == 2'd1) a8[0] = 1'b0;
      if (f3[1:0] == 2'd2) a8[1:0] = 2'b00;
      return {4'd0, a8, 5'd0, f3, r[11:7], 7'h03};
    end
    4'd7: begin
      f3 = {1'b0, s[19:18]};
      if (f3 == 3'd3) f3 = 3'd2;
      a8 = s[31:24];
      if (f3[1:0] == 2'd1) a8[0] = 1'b0;
      if (f3[1:0] == 2'd2) a8[1:0] = 2'b00;
      im = {4'd0, a8};
      return {im[11:5], r[24:20], 5'd0, f3, im[4:0], 7'h23};
    end
    4'd8, 4'd9, 4'd10, 4'd11: begin
      im = s[31:20];
      if (f3 == 3'd1) im[11:5] = 7'd0;
      if (f3 == 3'd5) im[11:5] = {1'b0, s[31], 5'd0};
      return {im, r[19:15], f3, r[11:7], 7'h13};
    end
    default: begin
      im[11:5] = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, s[31], 5'd0} : 7'd0;
      return {im[11:5], r[24:20], r[19:15], f3, r[11:7], 7'h33};
    end
  endcase
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_adr(input string name, input logic [31:0] exp,
                         input logic [31:0] act, input int t);
  test_chk[t]++;
  if (act !== exp) begin
    test_err[t]++;
    $display("** Error at %0t: %s expected %08h, got %08h", $time, name, exp, act);
  end
endtask

task automatic check_sel(input string name, input logic [3:0] exp,
                         input logic [3:0] act, input int t);
  test_chk[t]++;
  if (act !== exp) begin
    test_err[t]++;
    $display("** Error at %0t: %s expected %04b, got %04b", $time, name, exp, act);
  end
endtask

task automatic check_word(input string name, input logic [31:0] exp,
                          input logic [31:0] act, input int t);
  test_chk[t]++;
  if (act !== exp) begin
    test_err[t]++;
    $display("** Error at %0t: %s expected %08h, got %08h", $time, name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act,
                          input int t);
  test_chk[t]++;
  if (act !== exp) begin
    test_err[t]++;
    $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
  end
endtask

//////////////////////////////////////////////////
// bus events
//////////////////////////////////////////////////

// one completed data transfer against the model's access
task automatic data_transfer();
  logic [31:0] m_exp;
  logic [31:0] m_bus;
  int          t;
  if (!exp_vld) begin
    test_err[2]++;
    $display("data bus access at %0t with no load or store pending", $time);
  end else begin
    t = exp_wen ? 2 : 3;
    check_flag("ls_wen", exp_wen, ls_wen, t);
    check_adr("ls_adr", exp_adr, ls_adr, t);
    check_sel("ls_sel", exp_sel, ls_sel, t);
    // store data compared on the lanes the model writes
    if (exp_wen) begin
      m_exp = {{8{exp_sel[3]}}, {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}};
      check_word("ls_wdt", exp_wdt & m_exp, ls_wdt & m_exp, t);
    end
    // memory takes the lanes the bus selects
    if (ls_wen) begin
      m_bus = {{8{ls_sel[3]}}, {8{ls_sel[2]}}, {8{ls_sel[1]}}, {8{ls_sel[0]}}};
      dmem[ls_adr[7:2]] = (dmem[ls_adr[7:2]] & ~m_bus) | (ls_wdt & m_bus);
    end
    exp_vld = 1'b0;
  end
endtask

// model steps one instruction per accepted fetch
task automatic fetch_accept();
  check_adr("if_adr", iss_pc, if_adr, 1);
  if (exp_vld) begin
    test_err[1]++;
    $display("fetch at %0t before the pending memory access finished", $time);
  end
  if (steps == N_INSN) begin
    done_run = 1'b1;
  end else begin
    iss_step(pmem[iss_pc[9:2]]);
    steps++;
  end
endtask

//////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////

initial begin
  logic [31:0] s;
  rst        = 1'b1;
  if_rdt     = 32'd0;
  if_ack     = 1'b0;
  ls_rdt     = 32'd0;
  ls_ack     = 1'b0;
  lcg_state  = 32'd57;
  fetch_pend = 1'b0;
  fetch_adr  = 32'd0;
  done_run   = 1'b0;
  timed_out  = 1'b0;
  steps      = 0;
  cycles     = 0;
  exp_vld    = 1'b0;
  iss_pc     = 32'd0;
  for (int i = 0; i < 4; i++) begin
    test_chk[i] = 0;
    test_err[i] = 0;
  end
  for (int i = 0; i < 32; i++) begin
    iss_x[i] = 32'd0;
  end
  for (int i = 0; i < 256; i++) begin
    pmem[i] = random_insn(i);
  end
  // fill depends on the whole word address
  for (int i = 0; i < 64; i++) begin
    dmem[i]    = 32'h9e3779b9 * (i + 1);
    iss_mem[i] = dmem[i];
  end

  // both requests stay low while reset is held
  for (int i = 0; i < 5; i++) begin
    @(negedge clk);
    check_flag("if_req", 1'b0, if_req, 0);
    check_flag("ls_req", 1'b0, ls_req, 0);
  end
  @(posedge clk);
  #1 rst = 1'b0;
  @(negedge clk);
  check_flag("if_req", 1'b0, if_req, 0);
  check_flag("ls_req", 1'b0, ls_req, 0);
  $display("test reset: %0d checks, %0d errors", test_chk[0], test_err[0]);

  while (!done_run && !timed_out) begin
    @(posedge clk);
    #1;
    if (fetch_pend) begin
      if_rdt = pmem[fetch_adr[9:2]];
    end
    fetch_pend = 1'b0;
    // each ack low one cycle in four
    s = lcg_next();
    if_ack = (s[3:2] != 2'd0);
    ls_ack = (s[5:4] != 2'd0);
    #1;
    ls_rdt = dmem[ls_adr[7:2]];
    @(negedge clk);
    cycles++;
    if (ls_req && ls_ack) begin
      data_transfer();
    end
    if (if_req && if_ack) begin
      fetch_accept();
      fetch_pend = 1'b1;
      fetch_adr  = if_adr;
    end
    if (cycles >= MAX_CYCLES) begin
      timed_out = 1'b1;
    end
  end

  if (timed_out) begin
    $display("timeout after %0d cycles, only %0d instructions done", cycles, steps);
  end
  $display("test fetch: %0d checks, %0d errors", test_chk[1], test_err[1]);
  $display("test store: %0d checks, %0d errors", test_chk[2], test_err[2]);
  $display("test load: %0d checks, %0d errors", test_chk[3], test_err[3]);
  $display("total: %0d instructions, %0d checks, %0d errors", steps,
           test_chk[0] + test_chk[1] + test_chk[2] + test_chk[3],
           test_err[0] + test_err[1] + test_err[2] + test_err[3]);
  if (!timed_out && (test_err[0] + test_err[1] + test_err[2] + test_err[3] == 0)) begin
    $display("TESTBENCH PASSED");
  end else begin
    $display("TESTBENCH FAILED");
  end
  $finish;
end

endmodule

// File: verilog/r5p_alu.sv
`timescale 1ns/10ps

module r5p_alu (
  input  logic [r5p_ctl_pkg::AO_BITS-1:0]  ctl,
  input  logic [riscv_isa_pkg::XLEN-1:0]   rs1,
  input  logic [riscv_isa_pkg::XLEN-1:0]   rs2,
  output logic [riscv_isa_pkg::XLEN-1:0]   rd,
  output logic [riscv_isa_pkg::XLEN-1:0]   sum
);

import riscv_isa_pkg::*;
import r5p_ctl_pkg::*;

// adder shared by ADD, branch targets and load/store addresses
assign sum = rs1 + rs2;

always_comb begin
  case (ctl)
    AO_ADD:  rd = sum;
    AO_SUB:  rd = rs1 - rs2;
    AO_SLL:  rd = rs1 << rs2[4:0];
    // compares give 0 or 1
    AO_SLT:  rd = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
    AO_SLTU: rd = {{(XLEN-1){1'b0}}, rs1 < rs2};
    AO_XOR:  rd = rs1 ^ rs2;
    AO_SRL:  rd = rs1 >> rs2[4:0];
    // arithmetic shift keeps the sign
    AO_SRA:  rd = $signed(rs1) >>> rs2[4:0];
    AO_OR:   rd = rs1 | rs2;
    AO_AND:  rd = rs1 & rs2;
    AO_LUI:  rd = rs2;
    default: rd = '0;
  endcase
end

endmodule

// File: verilog/r5p_br.sv
`timescale 1ns/10ps

module r5p_br (
  input  logic [r5p_ctl_pkg::BR_BITS-1:0]  f3,
  input  logic                             jmp,
  input  logic [riscv_isa_pkg::XLEN-1:0]   rs1,
  input  logic [riscv_isa_pkg::XLEN-1:0]   rs2,
  output logic                             tkn
);

import riscv_isa_pkg::*;

logic eq;
logic lt;
logic ltu;
logic cnd;

// the three base compares
assign eq  = (rs1 == rs2);
assign lt  = ($signed(rs1) < $signed(rs2));
assign ltu = (rs1 < rs2);

always_comb begin
  case (f3)
    F3_BEQ:  cnd = eq;
    F3_BNE:  cnd = ~eq;
    F3_BLT:  cnd = lt;
    F3_BGE:  cnd = ~lt;
    F3_BLTU: cnd = ltu;
    F3_BGEU: cnd = ~ltu;
    default: cnd = 1'b0;
  endcase
end

// jumps are always taken
assign tkn = jmp | cnd;

endmodule

// File: verilog/r5p_core.sv
`timescale 1ns/10ps

module r5p_core (
  input  logic                             clk,
  input  logic                             rst,
  // program bus
  output logic                             if_req,
  output logic [riscv_isa_pkg::XLEN-1:0]   if_adr,
  input  logic [riscv_isa_pkg::XLEN-1:0]   if_rdt,
  input  logic                             if_ack,
  // raw data access to the LSU
  output logic                             mem_req,
  output logic                             mem_wen,
  output logic [r5p_ctl_pkg::SZ_BITS-1:0]  mem_size,
  output logic                             mem_uns,
  output logic [riscv_isa_pkg::XLEN-1:0]   mem_adr,
  output logic [riscv_isa_pkg::XLEN-1:0]   mem_wdt,
  input  logic [riscv_isa_pkg::XLEN-1:0]   mem_rdt,
  input  logic                             mem_ack
);

import riscv_isa_pkg::*;
import r5p_ctl_pkg::*;

// fetch and PC
logic               run;
logic [XLEN-1:0]    pc;
logic [XLEN-1:0]    pc4;
logic [XLEN-1:0]    pcn;
logic               id_vld;
logic               stall;
logic               done;

// decode
op32_t              id_op;
logic [AO_BITS-1:0] id_ao;
logic               id_pc_sel;
logic               id_a1_sel;
logic               id_a2_sel;
logic [WB_BITS-1:0] id_wb_sel;
logic [BR_BITS-1:0] id_br_f3;
logic               id_jmp;
logic               id_ld;
logic               id_st;
logic [SZ_BITS-1:0] id_size;
logic               id_uns;
logic [XLEN-1:0]    id_imm;

// registers and execute
logic               gpr_we;
logic [XLEN-1:0]    gpr_rs1;
logic [XLEN-1:0]    gpr_rs2;
logic [XLEN-1:0]    gpr_rd;
logic [XLEN-1:0]    alu_rs1;
logic [XLEN-1:0]    alu_rs2;
logic [XLEN-1:0]    alu_rd;
logic [XLEN-1:0]    alu_sum;
logic               tkn;

//////////////////////////////////////////////////
// fetch control
//////////////////////////////////////////////////

// fetching starts on the first clock after reset
always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    run <= 1'b0;
  end else begin
    run <= 1'b1;
  end
end

// waiting on the data bus freezes the whole pipe
assign stall  = id_vld & (id_ld | id_st) & ~mem_ack;
assign done   = id_vld & ~stall;
assign if_req = run & ~stall;
assign if_adr = pcn;

// decode valid, held over a stall
always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    id_vld <= 1'b0;
  end else if (!stall) begin
    id_vld <= if_req & if_ack;
  end
end

// pc follows pcn on completion, a refused fetch retries from pc
always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    pc <= '0;
  end else if (done) begin
    pc <= pcn;
  end
end

assign pc4 = pc + 32'd4;

always_comb begin
  if (done && (id_pc_sel == PC_ALU) && tkn) begin
    pcn = {alu_sum[XLEN-1:1], 1'b0};
  end else if (done) begin
    pcn = pc4;
  end else begin
    pcn = pc;
  end
end

//////////////////////////////////////////////////
// decode and registers
//////////////////////////////////////////////////

// fetched word stays on if_rdt until the next fetch
assign id_op = if_rdt;

r5p_dec dec (
  .op     (id_op),
  .ao     (id_ao),
  .pc_sel (id_pc_sel),
  .a1_sel (id_a1_sel),
  .a2_sel (id_a2_sel),
  .wb_sel (id_wb_sel),
  .br_f3  (id_br_f3),
  .jmp    (id_jmp),
  .ld     (id_ld),
  .st     (id_st),
  .size   (id_size),
  .uns    (id_uns),
  .imm    (id_imm)
);

// write on the completing edge only
assign gpr_we = done & (id_wb_sel != WB_NONE);

r5p_gpr gpr (
  .clk   (clk),
  .rst   (rst),
  .e_rd  (gpr_we),
  .a_rs1 (id_op.r.rs1),
  .a_rs2 (id_op.r.rs2),
  .a_rd  (id_op.r.rd),
  .d_rd  (gpr_rd),
  .d_rs1 (gpr_rs1),
  .d_rs2 (gpr_rs2)
);

//////////////////////////////////////////////////
// execute
//////////////////////////////////////////////////

// operand muxes
assign alu_rs1 = (id_a1_sel == A1_PC) ? pc : gpr_rs1;
assign alu_rs2 = (id_a2_sel == A2_IMM) ? id_imm : gpr_rs2;

r5p_alu alu (
  .ctl (id_ao),
  .rs1 (alu_rs1),
  .rs2 (alu_rs2),
  .rd  (alu_rd),
  .sum (alu_sum)
);

r5p_br br (
  .f3  (id_br_f3),
  .jmp (id_jmp),
  .rs1 (gpr_rs1),
  .rs2 (gpr_rs2),
  .tkn (tkn)
);

// writeback source
always_comb begin
  case (id_wb_sel)
    WB_PC4:  gpr_rd = pc4;
    WB_LD:   gpr_rd = mem_rdt;
    default: gpr_rd = alu_rd;
  endcase
end

// load/store, address from the shared adder
assign mem_req  = id_vld & (id_ld | id_st);
assign mem_wen  = id_st;
assign mem_size = id_size;
assign mem_uns  = id_uns;
assign mem_adr  = alu_sum;
assign mem_wdt  = gpr_rs2;

// every fetch address is word aligned, jump targets included
a_if_align: assert property (@(posedge clk) disable iff (rst)
  if_req |-> (if_adr[1:0] == 2'b00));

endmodule

// File: verilog/r5p_ctl_pkg.sv
package r5p_ctl_pkg;

  //////////////////////////////////////////////////
  // control field widths
  //////////////////////////////////////////////////

  localparam int unsigned AO_BITS = 4;
  localparam int unsigned WB_BITS = 2;
  localparam int unsigned SZ_BITS = 2;
  // branch funct3 passed through as is
  localparam int unsigned BR_BITS = 3;

  //////////////////////////////////////////////////
  // control codes
  //////////////////////////////////////////////////

  // ALU operation
  localparam logic [AO_BITS-1:0] AO_ADD  = 4'd0;
  localparam logic [AO_BITS-1:0] AO_SUB  = 4'd1;
  localparam logic [AO_BITS-1:0] AO_SLL  = 4'd2;
  localparam logic [AO_BITS-1:0] AO_SLT  = 4'd3;
  localparam logic [AO_BITS-1:0] AO_SLTU = 4'd4;
  localparam logic [AO_BITS-1:0] AO_XOR  = 4'd5;
  localparam logic [AO_BITS-1:0] AO_SRL  = 4'd6;
  localparam logic [AO_BITS-1:0] AO_SRA  = 4'd7;
  localparam logic [AO_BITS-1:0] AO_OR   = 4'd8;
  localparam logic [AO_BITS-1:0] AO_AND  = 4'd9;
  // operand 2 straight through
  localparam logic [AO_BITS-1:0] AO_LUI  = 4'd10;

  // next PC source
  localparam logic PC_PC4 = 1'b0;
  localparam logic PC_ALU = 1'b1;

  // ALU operand 1
  localparam logic A1_RS1 = 1'b0;
  localparam logic A1_PC  = 1'b1;

  // ALU operand 2
  localparam logic A2_RS2 = 1'b0;
  localparam logic A2_IMM = 1'b1;

  // writeback source
  localparam logic [WB_BITS-1:0] WB_NONE = 2'd0;
  localparam logic [WB_BITS-1:0] WB_ALU  = 2'd1;
  localparam logic [WB_BITS-1:0] WB_PC4  = 2'd2;
  localparam logic [WB_BITS-1:0] WB_LD   = 2'd3;

  // access size, same as funct3 bits 1:0
  localparam logic [SZ_BITS-1:0] SZ_B = 2'd0;
  localparam logic [SZ_BITS-1:0] SZ_H = 2'd1;
  localparam logic [SZ_BITS-1:0] SZ_W = 2'd2;

endpackage

// File: verilog/r5p_dec.sv
`timescale 1ns/10ps

module r5p_dec (
  input  riscv_isa_pkg::op32_t              op,
  output logic [r5p_ctl_pkg::AO_BITS-1:0]   ao,
  output logic                              pc_sel,
  output logic                              a1_sel,
  output logic                              a2_sel,
  output logic [r5p_ctl_pkg::WB_BITS-1:0]   wb_sel,
  output logic [r5p_ctl_pkg::BR_BITS-1:0]   br_f3,
  output logic                              jmp,
  output logic                              ld,
  output logic                              st,
  output logic [r5p_ctl_pkg::SZ_BITS-1:0]   size,
  output logic                              uns,
  output logic [riscv_isa_pkg::XLEN-1:0]    imm
);

import riscv_isa_pkg::*;
import r5p_ctl_pkg::*;

// funct3 to ALU code, sub and sra from funct7 bit 5
function automatic logic [AO_BITS-1:0] alu_op (
  input logic [2:0] f3,
  input logic       sub,
  input logic       sra
);
  logic [AO_BITS-1:0] o;
  case (f3)
    F3_ADD:  o = sub ? AO_SUB : AO_ADD;
    F3_SLL:  o = AO_SLL;
    F3_SLT:  o = AO_SLT;
    F3_SLTU: o = AO_SLTU;
    F3_XOR:  o = AO_XOR;
    F3_SR:   o = sra ? AO_SRA : AO_SRL;
    F3_OR:   o = AO_OR;
    F3_AND:  o = AO_AND;
    default: o = AO_ADD;
  endcase
  return o;
endfunction

//////////////////////////////////////////////////
// immediates
//////////////////////////////////////////////////

logic [XLEN-1:0] imm_i;
logic [XLEN-1:0] imm_s;
logic [XLEN-1:0] imm_b;
logic [XLEN-1:0] imm_u;
logic [XLEN-1:0] imm_j;

// all sign extended from the top instruction bit
assign imm_i = {{20{op.i.imm_11_0[11]}}, op.i.imm_11_0};
assign imm_s = {{20{op.s.imm_11_5[6]}}, op.s.imm_11_5, op.s.imm_4_0};
assign imm_b = {{19{op.b.imm_12}}, op.b.imm_12, op.b.imm_11,
                op.b.imm_10_5, op.b.imm_4_1, 1'b0};
assign imm_u = {op.u.imm_31_12, 12'h000};
assign imm_j = {{11{op.j.imm_20}}, op.j.imm_20, op.j.imm_19_12,
                op.j.imm_11, op.j.imm_10_1, 1'b0};

// funct3 fields used by branch unit and LSU
assign br_f3 = op.b.funct3;
assign size  = op.i.funct3[1:0];
assign uns   = op.i.funct3[2];

//////////////////////////////////////////////////
// control
//////////////////////////////////////////////////

always_comb begin
  // defaults, unknown opcode ends up as a nop
  ao     = AO_ADD;
  pc_sel = PC_PC4;
  a1_sel = A1_RS1;
  a2_sel = A2_IMM;
  wb_sel = WB_NONE;
  jmp    = 1'b0;
  ld     = 1'b0;
  st     = 1'b0;
  imm    = imm_i;
  case (op.r.opcode)
    OPC_LUI: begin
      ao     = AO_LUI;
      imm    = imm_u;
      wb_sel = WB_ALU;
    end
    OPC_AUIPC: begin
      a1_sel = A1_PC;
      imm    = imm_u;
      wb_sel = WB_ALU;
    end
    OPC_JAL: begin
      pc_sel = PC_ALU;
      jmp    = 1'b1;
      a1_sel = A1_PC;
      imm    = imm_j;
      wb_sel = WB_PC4;
    end
    OPC_JALR: begin
      // target from rs1 plus I immediate
      pc_sel = PC_ALU;
      jmp    = 1'b1;
      wb_sel = WB_PC4;
    end
    OPC_BRANCH: begin
      pc_sel = PC_ALU;
      a1_sel = A1_PC;
      imm    = imm_b;
    end
    OPC_LOAD: begin
      ld     = 1'b1;
      wb_sel = WB_LD;
    end
    OPC_STORE: begin
      st     = 1'b1;
      imm    = imm_s;
    end
    OPC_OP_IMM: begin
      // no SUBI, funct7 only selects SRAI
      ao     = alu_op(op.i.funct3, 1'b0, op.r.funct7[5]);
      wb_sel = WB_ALU;
    end
    OPC_OP: begin
      ao     = alu_op(op.r.funct3, op.r.funct7[5], op.r.funct7[5]);
      a2_sel = A2_RS2;
      wb_sel = WB_ALU;
    end
    default: begin
      wb_sel = WB_NONE;
    end
  endcase
end

endmodule

// File: verilog/r5p_gpr.sv
`timescale 1ns/10ps

module r5p_gpr (
  input  logic                            clk,
  input  logic                            rst,
  // write enable
  input  logic                            e_rd,
  // register indices
  input  logic [4:0]                      a_rs1,
  input  logic [4:0]                      a_rs2,
  input  logic [4:0]                      a_rd,
  // data
  input  logic [riscv_isa_pkg::XLEN-1:0]  d_rd,
  output logic [riscv_isa_pkg::XLEN-1:0]  d_rs1,
  output logic [riscv_isa_pkg::XLEN-1:0]  d_rs2
);

import riscv_isa_pkg::*;

logic [XLEN-1:0] gpr [0:31];

// x0 is cleared here and never written afterwards
always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    for (int i = 0; i < 32; i++) begin
      gpr[i] <= '0;
    end
  end else if (e_rd && (a_rd != 5'd0)) begin
    gpr[a_rd] <= d_rd;
  end
end

// asynchronous read ports
assign d_rs1 = gpr[a_rs1];
assign d_rs2 = gpr[a_rs2];

// x0 stays zero over the whole run
a_x0_zero: assert property (@(posedge clk) disable iff (rst)
  (a_rs1 == 5'd0) |-> (d_rs1 == '0));

endmodule

// File: verilog/r5p_lsu.sv
`timescale 1ns/10ps

module r5p_lsu (
  // raw access from the core
  input  logic                             mem_req,
  input  logic                             mem_wen,
  input  logic [r5p_ctl_pkg::SZ_BITS-1:0]  mem_size,
  input  logic                             mem_uns,
  input  logic [riscv_isa_pkg::XLEN-1:0]   mem_adr,
  input  logic [riscv_isa_pkg::XLEN-1:0]   mem_wdt,
  output logic [riscv_isa_pkg::XLEN-1:0]   mem_rdt,
  output logic                             mem_ack,
  // data bus
  output logic                             ls_req,
  output logic                             ls_wen,
  output logic [riscv_isa_pkg::XLEN-1:0]   ls_adr,
  output logic [3:0]                       ls_sel,
  output logic [riscv_isa_pkg::XLEN-1:0]   ls_wdt,
  input  logic [riscv_isa_pkg::XLEN-1:0]   ls_rdt,
  input  logic                             ls_ack
);

import riscv_isa_pkg::*;
import r5p_ctl_pkg::*;

logic [7:0]  ld_b;
logic [15:0] ld_h;

//////////////////////////////////////////////////
// request side
//////////////////////////////////////////////////

assign ls_req  = mem_req;
assign ls_wen  = mem_wen;
// bus only sees aligned words
assign ls_adr  = {mem_adr[XLEN-1:2], 2'b00};
assign mem_ack = ls_ack;

// lane select and store data replication
always_comb begin
  case (mem_size)
    SZ_B: begin
      ls_sel = 4'b0001 << mem_adr[1:0];
      ls_wdt = {4{mem_wdt[7:0]}};
    end
    SZ_H: begin
      ls_sel = {{2{mem_adr[1]}}, {2{~mem_adr[1]}}};
      ls_wdt = {2{mem_wdt[15:0]}};
    end
    SZ_W: begin
      ls_sel = 4'b1111;
      ls_wdt = mem_wdt;
    end
    default: begin
      ls_sel = 4'b0000;
      ls_wdt = mem_wdt;
    end
  endcase
end

//////////////////////////////////////////////////
// load data
//////////////////////////////////////////////////

assign ld_b = ls_rdt[8*mem_adr[1:0] +: 8];
assign ld_h = mem_adr[1] ? ls_rdt[31:16] : ls_rdt[15:0];

// sign fill unless LBU/LHU
always_comb begin
  case (mem_size)
    SZ_B:    mem_rdt = {{24{~mem_uns & ld_b[7]}}, ld_b};
    SZ_H:    mem_rdt = {{16{~mem_uns & ld_h[15]}}, ld_h};
    default: mem_rdt = ls_rdt;
  endcase
end

// the decoder never requests a size without lanes
always_comb begin
  if (ls_req) begin
    assert (ls_sel != 4'b0000)
      else $error("ls_sel empty on active request");
  end
end

endmodule

// File: verilog/r5p_top.sv
`timescale 1ns/10ps

module r5p_top (
  input  logic                             clk,
  input  logic                             rst,
  // program bus
  output logic                             if_req,
  output logic [riscv_isa_pkg::XLEN-1:0]   if_adr,
  input  logic [riscv_isa_pkg::XLEN-1:0]   if_rdt,
  input  logic                             if_ack,
  // data bus
  output logic                             ls_req,
  output logic                             ls_wen,
  output logic [riscv_isa_pkg::XLEN-1:0]   ls_adr,
  output logic [3:0]                       ls_sel,
  output logic [riscv_isa_pkg::XLEN-1:0]   ls_wdt,
  input  logic [riscv_isa_pkg::XLEN-1:0]   ls_rdt,
  input  logic                             ls_ack
);

import riscv_isa_pkg::*;
import r5p_ctl_pkg::*;

// core to LSU
logic               mem_req;
logic               mem_wen;
logic [SZ_BITS-1:0] mem_size;
logic               mem_uns;
logic [XLEN-1:0]    mem_adr;
logic [XLEN-1:0]    mem_wdt;
logic [XLEN-1:0]    mem_rdt;
logic               mem_ack;

r5p_core core (
  .clk      (clk),
  .rst      (rst),
  .if_req   (if_req),
  .if_adr   (if_adr),
  .if_rdt   (if_rdt),
  .if_ack   (if_ack),
  .mem_req  (mem_req),
  .mem_wen  (mem_wen),
  .mem_size (mem_size),
  .mem_uns  (mem_uns),
  .mem_adr  (mem_adr),
  .mem_wdt  (mem_wdt),
  .mem_rdt  (mem_rdt),
  .mem_ack  (mem_ack)
);

r5p_lsu lsu (
  .mem_req  (mem_req),
  .mem_wen  (mem_wen),
  .mem_size (mem_size),
  .mem_uns  (mem_uns),
  .mem_adr  (mem_adr),
  .mem_wdt  (mem_wdt),
  .mem_rdt  (mem_rdt),
  .mem_ack  (mem_ack),
  .ls_req   (ls_req),
  .ls_wen   (ls_wen),
  .ls_adr   (ls_adr),
  .ls_sel   (ls_sel),
  .ls_wdt   (ls_wdt),
  .ls_rdt   (ls_rdt),
  .ls_ack   (ls_ack)
);

endmodule

// File: verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

  //////////////////////////////////////////////////
  // base integer ISA
  //////////////////////////////////////////////////

  // register width, also both bus widths
  localparam int unsigned XLEN = 32;

  // major opcodes, instruction bits 6:0
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // loads, bit 2 marks zero extension
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // stores
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  //////////////////////////////////////////////////
  // instruction formats
  //////////////////////////////////////////////////

  // one 32-bit word, six views
  typedef union packed {
    // register-register
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    // immediate, loads, JALR
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    // stores
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    // branches, offset bit 0 implied
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    // upper immediate
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    // JAL
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } op32_t;

endpackage
